// ==== compile.f ====
+incdir+logic
logic/dram_cache_pkg.sv
logic/req_stage.sv
logic/line_store.sv
logic/cache_ctrl.sv
logic/dram_port.sv
logic/dram_cache_top.sv
test/tb_dram_model.sv
test/tb_dram_cache.sv

// ==== Bender.yml ====
package:
  name: dram_cache

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/dram_cache_pkg.sv
      - logic/req_stage.sv
      - logic/line_store.sv
      - logic/cache_ctrl.sv
      - logic/dram_port.sv
      - logic/dram_cache_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_dram_model.sv
      - test/tb_dram_cache.sv

// ==== test/tb_dram_cache.sv ====
`timescale 1ns/10ps
`include "dram_cache_cfg.svh"

module tb_dram_cache import dram_cache_pkg::*; ();

    localparam int MAX_TESTS  = 32;
    localparam int WAIT_LIMIT = 200;  // cycles per test

    logic                   CLK;
    logic                   i_rrst_x;
    logic                   i_req_valid;
    logic                   i_req_write;
    acc_size_e              i_req_size;
    logic [`DC_ADDR_W-1:0]  i_req_addr;
    logic [`DC_WORD_W-1:0]  i_req_wdata;
    logic                   o_req_ready;
    logic                   o_rsp_valid;
    logic [`DC_LINE_W-1:0]  o_rsp_line;
    logic                   i_rsp_ready;
    logic                   o_mem_wr_valid;
    logic [`DC_ADDR_W-1:0]  o_mem_wr_addr;
    logic [`DC_WORD_W-1:0]  o_mem_wr_data;
    logic [`DC_BYTES_W-1:0] o_mem_wr_mask;
    logic                   i_mem_wr_ready;
    logic                   o_mem_rd_valid;
    logic [`DC_ADDR_W-1:0]  o_mem_rd_addr;
    logic                   i_mem_rd_ready;
    logic                   i_mem_rd_valid;
    logic [`DC_LINE_W-1:0]  i_mem_rd_data;

    // stimulus table with expected values
    logic                   t_wr   [MAX_TESTS];
    acc_size_e              t_size [MAX_TESTS];
    logic [`DC_ADDR_W-1:0]  t_addr [MAX_TESTS];
    logic [`DC_WORD_W-1:0]  t_data [MAX_TESTS];
    logic                   t_miss [MAX_TESTS];
    logic [`DC_LINE_W-1:0]  t_line [MAX_TESTS];
    logic [`DC_BYTES_W-1:0] t_mask [MAX_TESTS];
    logic [`DC_WORD_W-1:0]  t_rep  [MAX_TESTS];
    int                     n_tests = 0;

    logic [31:0]            ref_mem [logic [29:0]];  // what DRAM should hold
    logic [31:0]            rand_state = 32'h20b3_80a9;
    int                     errors = 0;
    int                     checks = 0;
    int                     rd_count = 0;
    int                     wr_count = 0;
    logic [`DC_ADDR_W-1:0]  last_rd_addr;
    logic [`DC_ADDR_W-1:0]  last_wr_addr;
    logic [`DC_WORD_W-1:0]  last_wr_data;
    logic [`DC_BYTES_W-1:0] last_wr_mask;

    dram_cache_top dram_cache_top_i (.*);

    tb_dram_model dram_model_i (
        .CLK        (CLK),
        .i_rrst_x   (i_rrst_x),
        .i_wr_valid (o_mem_wr_valid),
        .i_wr_addr  (o_mem_wr_addr),
        .i_wr_data  (o_mem_wr_data),
        .i_wr_mask  (o_mem_wr_mask),
        .o_wr_ready (i_mem_wr_ready),
        .i_rd_valid (o_mem_rd_valid),
        .i_rd_addr  (o_mem_rd_addr),
        .o_rd_ready (i_mem_rd_ready),
        .o_rd_valid (i_mem_rd_valid),
        .o_rd_data  (i_mem_rd_data)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #10 CLK = ~CLK;
        end
    end

    function logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // same starting contents as the memory model
    function automatic logic [31:0] ref_word(input logic [29:0] wa);
        if (ref_mem.exists(wa)) begin
            return ref_mem[wa];
        end
        return {wa, 2'b00} * 32'h9e37_79b1 ^ 32'h5a5a_0f0f;
    endfunction

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic add_entry(input logic wr, input acc_size_e size,
                             input logic [31:0] addr, input logic [31:0] data,
                             input logic miss);
        logic [3:0]   mask;
        logic [31:0]  rep;
        logic [31:0]  word;
        logic [127:0] line;
        case (size)
            ACC_BYTE: begin
                mask           = 4'b0000;
                mask[addr[1:0]] = 1'b1;
                rep  = {data[7:0], data[7:0], data[7:0], data[7:0]};
            end
            ACC_HALF: begin
                mask = addr[1] ? 4'b1100 : 4'b0011;
                rep  = {data[15:0], data[15:0]};
            end
            default: begin
                mask = 4'b1111;
                rep  = data;
            end
        endcase
        line = '0;
        if (wr) begin
            word = ref_word(addr[31:2]);
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    word[8*b +: 8] = rep[8*b +: 8];
                end
            end
            ref_mem[addr[31:2]] = word;
        end else begin
            for (int w = 0; w < 4; w++) begin
                line[32*w +: 32] = ref_word({addr[31:4], w[1:0]});
            end
        end
        t_wr[n_tests]   = wr;
        t_size[n_tests] = size;
        t_addr[n_tests] = addr;
        t_data[n_tests] = data;
        t_miss[n_tests] = miss;
        t_line[n_tests] = line;
        t_mask[n_tests] = mask;
        t_rep[n_tests]  = rep;
        n_tests++;
    endtask

    task automatic build_table();
        add_entry(1'b0, ACC_WORD, 32'h0000_1040, 32'h0, 1'b1);  // cold miss
        add_entry(1'b0, ACC_WORD, 32'h0000_1048, 32'h0, 1'b0);  // same line hits
        add_entry(1'b1, ACC_BYTE, 32'h0000_1041, 32'h0000_00ab, 1'b0);
        add_entry(1'b1, ACC_HALF, 32'h0000_1046, 32'h0000_1234, 1'b0);
        add_entry(1'b1, ACC_WORD, 32'h0000_1048, 32'hdead_beef, 1'b0);
        add_entry(1'b0, ACC_WORD, 32'h0000_1040, 32'h0, 1'b0);  // merged bytes
        add_entry(1'b1, ACC_BYTE, 32'h0000_2083, 32'h0000_005c, 1'b0);  // no allocate
        add_entry(1'b1, ACC_HALF, 32'h0000_2080, 32'h0000_77aa, 1'b0);
        add_entry(1'b0, ACC_WORD, 32'h0000_2080, 32'h0, 1'b1);
        add_entry(1'b0, ACC_WORD, 32'h0000_208c, 32'h0, 1'b0);
        add_entry(1'b0, ACC_WORD, 32'h0000_3100, 32'h0, 1'b1);  // index 0x10, two tags
        add_entry(1'b0, ACC_WORD, 32'h0000_7100, 32'h0, 1'b1);
        add_entry(1'b0, ACC_WORD, 32'h0000_310c, 32'h0, 1'b1);
        add_entry(1'b0, ACC_WORD, 32'h0000_7104, 32'h0, 1'b1);
        add_entry(1'b1, ACC_HALF, 32'h0000_7102, 32'h0000_beef, 1'b0);
        add_entry(1'b0, ACC_WORD, 32'h0000_7108, 32'h0, 1'b0);
        add_entry(1'b0, ACC_WORD, 32'h0000_3104, 32'h0, 1'b1);
        add_entry(1'b1, ACC_WORD, 32'h0001_0ff4, 32'h0bad_f00d, 1'b0);
        add_entry(1'b0, ACC_WORD, 32'h0001_0ff0, 32'h0, 1'b1);
        add_entry(1'b1, ACC_BYTE, 32'h0001_0ff6, 32'h0000_0042, 1'b0);  // hit, lane 2
        add_entry(1'b0, ACC_WORD, 32'h0001_0ffc, 32'h0, 1'b0);
    endtask

    // DRAM handshakes counted on the rising edge
    always @(posedge CLK) begin
        if (i_rrst_x && o_mem_rd_valid && i_mem_rd_ready) begin
            rd_count++;
            last_rd_addr = o_mem_rd_addr;
        end
        if (i_rrst_x && o_mem_wr_valid && i_mem_wr_ready) begin
            wr_count++;
            last_wr_addr = o_mem_wr_addr;
            last_wr_data = o_mem_wr_data;
            last_wr_mask = o_mem_wr_mask;
        end
    end

    task automatic run_test(input int t);
        int               err0;
        int               rd0;
        int               wr0;
        int               n;
        logic             held;
        logic             done;
        logic [31:0]      r;
        logic [127:0]     held_line;
        logic [127:0]     got;
        err0 = errors;
        rd0  = rd_count;
        wr0  = wr_count;
        n    = 0;
        while (!o_req_ready && n < WAIT_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        i_req_valid = 1'b1;
        i_req_write = t_wr[t];
        i_req_size  = t_size[t];
        i_req_addr  = t_addr[t];
        i_req_wdata = t_data[t];
        @(negedge CLK);  // o_req_ready was high, so it transferred
        i_req_valid = 1'b0;
        held = 1'b0;
        done = 1'b0;
        got  = '0;
        n    = 0;
        if (!t_wr[t]) begin
            while (!done && n < WAIT_LIMIT) begin
                if (o_rsp_valid) begin
                    if (held) begin
                        check(o_rsp_line == held_line, "response line changed while stalled");
                        check(!o_req_ready, "request ready during a stalled response");
                    end
                    r           = next_rand();
                    i_rsp_ready = r[31:30] == 2'b00;
                    held        = !i_rsp_ready;
                    held_line   = o_rsp_line;
                    got         = o_rsp_line;
                    done        = i_rsp_ready;
                end
                @(negedge CLK);
                n++;
            end
            i_rsp_ready = 1'b0;
            if (!done) begin
                $display("test %0d timed out waiting for the read response", t);
                errors++;
            end
            check(got == t_line[t],
                  $sformatf("line %h, expected %h", got, t_line[t]));
            check(rd_count - rd0 == int'(t_miss[t]),
                  $sformatf("%0d DRAM reads, expected %0d", rd_count - rd0, t_miss[t]));
            if (t_miss[t]) begin
                check(last_rd_addr == {t_addr[t][31:4], 4'b0000},
                      $sformatf("read addr %h for %h", last_rd_addr, t_addr[t]));
            end
        end else begin
            while (!(o_req_ready && wr_count != wr0) && n < WAIT_LIMIT) begin
                @(negedge CLK);
                n++;
            end
            if (n >= WAIT_LIMIT) begin
                $display("test %0d timed out waiting for the store to reach DRAM", t);
                errors++;
            end
            check(wr_count - wr0 == 1, "store did not give exactly one DRAM write");
            check(last_wr_addr == {t_addr[t][31:2], 2'b00},
                  $sformatf("write addr %h for %h", last_wr_addr, t_addr[t]));
            check(last_wr_mask == t_mask[t],
                  $sformatf("write mask %b, expected %b", last_wr_mask, t_mask[t]));
            check(last_wr_data == t_rep[t],
                  $sformatf("write data %h, expected %h", last_wr_data, t_rep[t]));
            check(rd_count == rd0, "store caused a DRAM read");
        end
        $display("test %0d %s %h: %s", t, t_wr[t] ? "write" : "read ", t_addr[t],
                 (errors == err0) ? "ok" : "failed");
    endtask

    initial begin
        wait (i_rrst_x === 1'b1);  // table is complete once reset is released
        repeat (n_tests * 200 + 100) @(posedge CLK);
        $display("run did not finish within %0d cycles", n_tests * 200 + 100);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        i_rrst_x    = 1'b0;
        i_req_valid = 1'b0;
        i_req_write = 1'b0;
        i_req_size  = ACC_WORD;
        i_req_addr  = '0;
        i_req_wdata = '0;
        i_rsp_ready = 1'b0;
        build_table();
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        i_rrst_x = 1'b1;
        check(o_req_ready, "o_req_ready low after reset");
        check(!o_rsp_valid && !o_mem_wr_valid && !o_mem_rd_valid,
              "a valid output high after reset");
        repeat (70) @(negedge CLK);  // let the array clear its valid bits
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== test/tb_dram_model.sv ====
`timescale 1ns/10ps
`include "dram_cache_cfg.svh"

module tb_dram_model (
    input  logic                   CLK,
    input  logic                   i_rrst_x,
    input  logic                   i_wr_valid,
    input  logic [`DC_ADDR_W-1:0]  i_wr_addr,
    input  logic [`DC_WORD_W-1:0]  i_wr_data,
    input  logic [`DC_BYTES_W-1:0] i_wr_mask,
    output logic                   o_wr_ready,
    input  logic                   i_rd_valid,
    input  logic [`DC_ADDR_W-1:0]  i_rd_addr,
    output logic                   o_rd_ready,
    output logic                   o_rd_valid,
    output logic [`DC_LINE_W-1:0]  o_rd_data
);

    logic [31:0] mem [logic [29:0]];       // word addressed, sparse
    logic [31:0] rand_state = 32'h20b3_80a9;
    logic        rd_pend;
    logic [29:0] rd_word;
    int          rd_delay;

    // contents of a word never written, spread over the whole address
    function automatic logic [31:0] init_word(input logic [29:0] wa);
        return {wa, 2'b00} * 32'h9e37_79b1 ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] read_word(input logic [29:0] wa);
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return init_word(wa);
    endfunction

    function logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    initial begin
        o_wr_ready = 1'b0;
        o_rd_ready = 1'b0;
        o_rd_valid = 1'b0;
        o_rd_data  = '0;
        rd_pend    = 1'b0;
        rd_word    = '0;
        rd_delay   = 0;
    end

    // handshakes as seen on the rising edge
    always @(posedge CLK) begin : capture
        logic [31:0] word;
        if (i_rrst_x && i_wr_valid && o_wr_ready) begin
            word = read_word(i_wr_addr[31:2]);
            for (int b = 0; b < 4; b++) begin
                if (i_wr_mask[b]) begin
                    word[8*b +: 8] = i_wr_data[8*b +: 8];
                end
            end
            mem[i_wr_addr[31:2]] = word;
        end
        if (i_rrst_x && i_rd_valid && o_rd_ready) begin
            rd_pend  = 1'b1;
            rd_word  = i_rd_addr[31:2];
            rd_delay = next_rand() % 6;  // line comes back after 0..5 extra cycles
        end
    end

    always @(negedge CLK) begin : drive
        logic [31:0] r;
        r = next_rand();
        o_rd_valid <= 1'b0;
        if (!i_rrst_x) begin
            o_wr_ready <= 1'b0;
            o_rd_ready <= 1'b0;
            rd_pend = 1'b0;
        end else begin
            o_wr_ready <= r[31:30] != 2'b00;  // stall about a quarter of the time
            o_rd_ready <= !rd_pend && r[29:28] != 2'b00;
            if (rd_pend) begin
                if (rd_delay == 0) begin
                    o_rd_valid <= 1'b1;
                    for (int w = 0; w < 4; w++) begin
                        o_rd_data[32*w +: 32] <= read_word({rd_word[29:2], w[1:0]});
                    end
                    rd_pend = 1'b0;
                end else begin
                    rd_delay = rd_delay - 1;
                end
            end
        end
    end

endmodule

// ==== logic/dram_cache_top.sv ====
`timescale 1ns/10ps
`include "dram_cache_cfg.svh"

module dram_cache_top import dram_cache_pkg::*; (
    input  logic                   CLK,
    input  logic                   i_rrst_x,
    input  logic                   i_req_valid,
    input  logic                   i_req_write,
    input  acc_size_e              i_req_size,
    input  logic [`DC_ADDR_W-1:0]  i_req_addr,
    input  logic [`DC_WORD_W-1:0]  i_req_wdata,
    output logic                   o_req_ready,
    output logic                   o_rsp_valid,
    output logic [`DC_LINE_W-1:0]  o_rsp_line,
    input  logic                   i_rsp_ready,
    output logic                   o_mem_wr_valid,
    output logic [`DC_ADDR_W-1:0]  o_mem_wr_addr,
    output logic [`DC_WORD_W-1:0]  o_mem_wr_data,
    output logic [`DC_BYTES_W-1:0] o_mem_wr_mask,
    input  logic                   i_mem_wr_ready,
    output logic                   o_mem_rd_valid,
    output logic [`DC_ADDR_W-1:0]  o_mem_rd_addr,
    input  logic                   i_mem_rd_ready,
    input  logic                   i_mem_rd_valid,
    input  logic [`DC_LINE_W-1:0]  i_mem_rd_data
);

    logic                   op_valid;
    logic                   op_ready;
    logic                   op_write;
    dc_addr_u               op_addr;   // held request, shared by all three
    logic [`DC_WORD_W-1:0]  op_wdata;
    logic [`DC_BYTES_W-1:0] op_mask;
    logic                   lookup;
    logic                   hit;
    logic [`DC_LINE_W-1:0]  line;
    logic                   fill;
    logic                   merge;
    logic                   wb_push;
    logic                   wb_full;
    logic                   rd_start;
    logic                   rd_done;
    logic [`DC_LINE_W-1:0]  rd_line;

    req_stage req_stage_i (
        .CLK         (CLK),
        .i_rrst_x    (i_rrst_x),
        .i_req_valid (i_req_valid),
        .i_req_write (i_req_write),
        .i_req_size  (i_req_size),
        .i_req_addr  (i_req_addr),
        .i_req_wdata (i_req_wdata),
        .o_req_ready (o_req_ready),
        .o_op_valid  (op_valid),
        .i_op_ready  (op_ready),
        .o_op_write  (op_write),
        .o_op_addr   (op_addr),
        .o_op_wdata  (op_wdata),
        .o_op_mask   (op_mask)
    );

    cache_ctrl cache_ctrl_i (
        .CLK         (CLK),
        .i_rrst_x    (i_rrst_x),
        .i_op_valid  (op_valid),
        .o_op_ready  (op_ready),
        .i_op_write  (op_write),
        .i_op_addr   (op_addr),
        .i_op_wdata  (op_wdata),
        .i_op_mask   (op_mask),
        .o_lookup    (lookup),
        .i_hit       (hit),
        .i_line      (line),
        .o_fill      (fill),
        .o_merge     (merge),
        .o_wb_push   (wb_push),
        .i_wb_full   (wb_full),
        .o_rd_start  (rd_start),
        .i_rd_done   (rd_done),
        .i_rd_line   (rd_line),
        .o_rsp_valid (o_rsp_valid),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp_line  (o_rsp_line)
    );

    line_store line_store_i (
        .CLK         (CLK),
        .i_rrst_x    (i_rrst_x),
        .i_lookup    (lookup),
        .i_addr      (op_addr),
        .i_fill      (fill),
        .i_fill_line (rd_line),
        .i_merge     (merge),
        .i_wdata     (op_wdata),
        .i_mask      (op_mask),
        .o_hit       (hit),
        .o_line      (line)
    );

    dram_port dram_port_i (
        .CLK            (CLK),
        .i_rrst_x       (i_rrst_x),
        .i_wb_push      (wb_push),
        .i_addr         (op_addr),
        .i_wdata        (op_wdata),
        .i_mask         (op_mask),
        .o_wb_full      (wb_full),
        .i_rd_start     (rd_start),
        .o_rd_done      (rd_done),
        .o_rd_line      (rd_line),
        .o_mem_wr_valid (o_mem_wr_valid),
        .o_mem_wr_addr  (o_mem_wr_addr),
        .o_mem_wr_data  (o_mem_wr_data),
        .o_mem_wr_mask  (o_mem_wr_mask),
        .i_mem_wr_ready (i_mem_wr_ready),
        .o_mem_rd_valid (o_mem_rd_valid),
        .o_mem_rd_addr  (o_mem_rd_addr),
        .i_mem_rd_ready (i_mem_rd_ready),
        .i_mem_rd_valid (i_mem_rd_valid),
        .i_mem_rd_data  (i_mem_rd_data)
    );

endmodule

// ==== logic/dram_port.sv ====
`timescale 1ns/10ps
`include "dram_cache_cfg.svh"

module dram_port import dram_cache_pkg::*; (
    input  logic                   CLK,
    input  logic                   i_rrst_x,
    input  logic                   i_wb_push,
    input  dc_addr_u               i_addr,
    input  logic [`DC_WORD_W-1:0]  i_wdata,
    input  logic [`DC_BYTES_W-1:0] i_mask,
    output logic                   o_wb_full,
    input  logic                   i_rd_start,
    output logic                   o_rd_done,
    output logic [`DC_LINE_W-1:0]  o_rd_line,
    output logic                   o_mem_wr_valid,
    output logic [`DC_ADDR_W-1:0]  o_mem_wr_addr,
    output logic [`DC_WORD_W-1:0]  o_mem_wr_data,
    output logic [`DC_BYTES_W-1:0] o_mem_wr_mask,
    input  logic                   i_mem_wr_ready,
    output logic                   o_mem_rd_valid,
    output logic [`DC_ADDR_W-1:0]  o_mem_rd_addr,
    input  logic                   i_mem_rd_ready,
    input  logic                   i_mem_rd_valid,
    input  logic [`DC_LINE_W-1:0]  i_mem_rd_data
);

    logic r_wb_full;
    logic r_rd_req;   // latched, not yet accepted
    logic r_rd_wait;  // accepted, line not back yet
    logic r_rd_done;

    assign o_wb_full      = r_wb_full;
    assign o_mem_wr_valid = r_wb_full;
    assign o_mem_rd_valid = r_rd_req && !r_wb_full;  // reads stay behind the store
    assign o_rd_done      = r_rd_done;

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_wb_full <= 1'b0;
            r_rd_req  <= 1'b0;
            r_rd_wait <= 1'b0;
            r_rd_done <= 1'b0;
        end else begin
            if (i_wb_push) begin
                r_wb_full <= 1'b1;
            end else if (o_mem_wr_valid && i_mem_wr_ready) begin
                r_wb_full <= 1'b0;
            end
            if (i_rd_start) begin
                r_rd_req <= 1'b1;
            end else if (o_mem_rd_valid && i_mem_rd_ready) begin
                r_rd_req  <= 1'b0;
                r_rd_wait <= 1'b1;
            end
            r_rd_done <= r_rd_wait && i_mem_rd_valid;  // one cycle pulse
            if (r_rd_wait && i_mem_rd_valid) begin
                r_rd_wait <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (i_wb_push) begin
            o_mem_wr_addr <= {i_addr.raw[`DC_ADDR_W-1:2], 2'b00};
            o_mem_wr_data <= i_wdata;
            o_mem_wr_mask <= i_mask;
        end
        if (i_rd_start) begin
            o_mem_rd_addr <= {i_addr.f.tag, i_addr.f.index, {`DC_OFFSET_W{1'b0}}};
        end
        if (r_rd_wait && i_mem_rd_valid) begin
            o_rd_line <= i_mem_rd_data;
        end
    end

    a_no_push_full: assert property (@(posedge CLK) disable iff (!i_rrst_x)
        i_wb_push |-> !r_wb_full);

    a_one_read: assert property (@(posedge CLK) disable iff (!i_rrst_x)
        i_rd_start |-> !(r_rd_req || r_rd_wait));

endmodule

// ==== logic/cache_ctrl.sv ====
`timescale 1ns/10ps
`include "dram_cache_cfg.svh"

module cache_ctrl import dram_cache_pkg::*; (
    input  logic                   CLK,
    input  logic                   i_rrst_x,
    input  logic                   i_op_valid,
    output logic                   o_op_ready,
    input  logic                   i_op_write,
    input  dc_addr_u               i_op_addr,
    input  logic [`DC_WORD_W-1:0]  i_op_wdata,
    input  logic [`DC_BYTES_W-1:0] i_op_mask,
    output logic                   o_lookup,
    input  logic                   i_hit,
    input  logic [`DC_LINE_W-1:0]  i_line,
    output logic                   o_fill,
    output logic                   o_merge,
    output logic                   o_wb_push,
    input  logic                   i_wb_full,
    output logic                   o_rd_start,
    input  logic                   i_rd_done,
    input  logic [`DC_LINE_W-1:0]  i_rd_line,
    output logic                   o_rsp_valid,
    input  logic                   i_rsp_ready,
    output logic [`DC_LINE_W-1:0]  o_rsp_line
);

    ctrl_state_e           r_state;
    ctrl_state_e           w_next;
    logic [`DC_LINE_W-1:0] r_rsp_line;

    assign o_rsp_valid = (r_state == ST_RESPOND);
    assign o_rsp_line  = r_rsp_line;

    // the request stays in req_stage until o_op_ready,
    // so the array and the DRAM side read it from there
    always_comb begin
        w_next     = r_state;
        o_op_ready = 1'b0;
        o_lookup   = 1'b0;
        o_fill     = 1'b0;
        o_merge    = 1'b0;
        o_wb_push  = 1'b0;
        o_rd_start = 1'b0;
        case (r_state)
            ST_IDLE: begin
                o_lookup = i_op_valid;
                if (i_op_valid) begin
                    w_next = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (i_op_write) begin
                    w_next = ST_WBUF_WAIT;
                end else if (i_hit) begin
                    w_next = ST_RESPOND;
                end else begin
                    o_rd_start = 1'b1;  // read miss, fetch the line
                    w_next     = ST_FILL_WAIT;
                end
            end
            ST_WBUF_WAIT: begin
                if (!i_wb_full) begin
                    o_wb_push  = 1'b1;   // store goes through to DRAM
                    o_merge    = i_hit;  // no allocate on a miss
                    o_op_ready = 1'b1;
                    w_next     = ST_IDLE;
                end
            end
            ST_FILL_WAIT: begin
                if (i_rd_done) begin
                    o_fill = 1'b1;
                    w_next = ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                if (i_rsp_ready) begin
                    o_op_ready = 1'b1;
                    w_next     = ST_IDLE;
                end
            end
            default: begin
                w_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_state <= ST_IDLE;
        end else begin
            r_state <= w_next;
        end
    end

    always_ff @(posedge CLK) begin
        if (r_state == ST_LOOKUP && !i_op_write && i_hit) begin
            r_rsp_line <= i_line;
        end else if (o_fill) begin
            r_rsp_line <= i_rd_line;  // same line that goes into the array
        end
    end

    a_rsp_hold: assert property (@(posedge CLK) disable iff (!i_rrst_x)
        o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp_line));

    // req_stage keeps the op steady for the whole sequence
    a_op_hold: assert property (@(posedge CLK) disable iff (!i_rrst_x)
        r_state != ST_IDLE && !o_op_ready
        |=> $stable({i_op_write, i_op_addr, i_op_wdata, i_op_mask}));

endmodule

// ==== logic/line_store.sv ====
`timescale 1ns/10ps
`include "dram_cache_cfg.svh"

module line_store import dram_cache_pkg::*; (
    input  logic                   CLK,
    input  logic                   i_rrst_x,
    input  logic                   i_lookup,
    input  dc_addr_u               i_addr,
    input  logic                   i_fill,
    input  logic [`DC_LINE_W-1:0]  i_fill_line,
    input  logic                   i_merge,
    input  logic [`DC_WORD_W-1:0]  i_wdata,
    input  logic [`DC_BYTES_W-1:0] i_mask,
    output logic                   o_hit,
    output logic [`DC_LINE_W-1:0]  o_line
);

    logic [`DC_TAG_W-1:0]   r_tag_mem  [`DC_LINES];
    logic [`DC_LINE_W-1:0]  r_line_mem [`DC_LINES];
    logic [`DC_LINES-1:0]   r_valid;
    logic [`DC_TAG_W-1:0]   r_tag_q;   // tag of the request
    logic [`DC_TAG_W-1:0]   r_tag_rd;  // tag stored in the entry
    logic                   r_valid_rd;
    logic [`DC_LINE_W-1:0]  r_line_rd;
    logic                   r_walk;
    logic [`DC_INDEX_W-1:0] r_walk_idx;
    logic [`DC_WORD_W-1:0]  w_word_mask;
    logic [`DC_LINE_W-1:0]  w_lane_mask;
    logic [`DC_LINE_W-1:0]  w_lane_data;
    logic [`DC_LINE_W-1:0]  w_merge_line;

    assign w_word_mask = {{8{i_mask[3]}}, {8{i_mask[2]}}, {8{i_mask[1]}}, {8{i_mask[0]}}};
    assign w_lane_mask = {{(`DC_LINE_W-`DC_WORD_W){1'b0}}, w_word_mask}
                         << {i_addr.f.wsel, 5'b0};
    assign w_lane_data = {{(`DC_LINE_W-`DC_WORD_W){1'b0}}, i_wdata}
                         << {i_addr.f.wsel, 5'b0};
    assign w_merge_line = (r_line_rd & ~w_lane_mask) | (w_lane_data & w_lane_mask);

    assign o_hit  = r_valid_rd && (r_tag_rd == r_tag_q);
    assign o_line = r_line_rd;

    // valid bits are cleared one index per cycle after reset,
    // every lookup misses until the walk is through
    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_walk     <= 1'b1;
            r_walk_idx <= '0;
            r_valid_rd <= 1'b0;
        end else begin
            if (r_walk) begin
                r_valid[r_walk_idx] <= 1'b0;
                r_walk_idx          <= r_walk_idx + 1'b1;
                if (&r_walk_idx) begin
                    r_walk <= 1'b0;
                end
            end
            if (i_fill) begin
                r_valid[i_addr.f.index] <= 1'b1;  // wins over the walk
            end
            if (i_lookup) begin
                r_valid_rd <= r_valid[i_addr.f.index] && !r_walk;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (i_fill || i_merge) begin
            r_tag_mem[i_addr.f.index]  <= i_addr.f.tag;
            r_line_mem[i_addr.f.index] <= i_fill ? i_fill_line : w_merge_line;
        end
        if (i_lookup) begin
            r_tag_q   <= i_addr.f.tag;
            r_tag_rd  <= r_tag_mem[i_addr.f.index];
            r_line_rd <= r_line_mem[i_addr.f.index];
        end
    end

    a_fill_xor_merge: assert property (@(posedge CLK) disable iff (!i_rrst_x)
        !(i_fill && i_merge));

endmodule

// ==== logic/req_stage.sv ====
`timescale 1ns/10ps
`include "dram_cache_cfg.svh"

module req_stage import dram_cache_pkg::*; (
    input  logic                   CLK,
    input  logic                   i_rrst_x,
    input  logic                   i_req_valid,
    input  logic                   i_req_write,
    input  acc_size_e              i_req_size,
    input  logic [`DC_ADDR_W-1:0]  i_req_addr,
    input  logic [`DC_WORD_W-1:0]  i_req_wdata,
    output logic                   o_req_ready,
    output logic                   o_op_valid,
    input  logic                   i_op_ready,
    output logic                   o_op_write,
    output dc_addr_u               o_op_addr,
    output logic [`DC_WORD_W-1:0]  o_op_wdata,
    output logic [`DC_BYTES_W-1:0] o_op_mask
);

    logic                   r_valid;
    logic                   w_accept;
    dc_addr_u               w_addr;
    logic [`DC_BYTES_W-1:0] w_mask;
    logic [`DC_WORD_W-1:0]  w_wdata;

    assign w_accept    = i_req_valid && o_req_ready;
    assign w_addr      = i_req_addr;
    assign o_req_ready = !r_valid;   // one deep, no bypass
    assign o_op_valid  = r_valid;

    // byte lanes and replicated store data from the size field
    always_comb begin
        case (i_req_size)
            ACC_BYTE: begin
                w_mask  = 4'b0001 << w_addr.f.bsel;
                w_wdata = {4{i_req_wdata[7:0]}};
            end
            ACC_HALF: begin
                w_mask  = 4'b0011 << {w_addr.f.bsel[1], 1'b0};
                w_wdata = {2{i_req_wdata[15:0]}};
            end
            default: begin
                w_mask  = 4'b1111;
                w_wdata = i_req_wdata;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_valid <= 1'b0;
        end else if (w_accept) begin
            r_valid <= 1'b1;
        end else if (o_op_valid && i_op_ready) begin
            r_valid <= 1'b0;  // controller finished with it
        end
    end

    always_ff @(posedge CLK) begin
        if (w_accept) begin
            o_op_write <= i_req_write;
            o_op_addr  <= w_addr;
            o_op_wdata <= w_wdata;
            o_op_mask  <= w_mask;
        end
    end

    a_no_rsvd_size: assert property (@(posedge CLK) disable iff (!i_rrst_x)
        w_accept |-> i_req_size != 2'd3);

endmodule

// ==== logic/dram_cache_pkg.sv ====
package dram_cache_pkg;

`include "dram_cache_cfg.svh"

    // size field of a client access, value 3 is reserved
    typedef enum logic [1:0] {
        ACC_BYTE = 2'd0,
        ACC_HALF = 2'd1,
        ACC_WORD = 2'd2
    } acc_size_e;

    // flat word for the DRAM write port, fields for the cache array
    typedef union packed {
        logic [`DC_ADDR_W-1:0] raw;
        struct packed {
            logic [`DC_TAG_W-1:0]   tag;
            logic [`DC_INDEX_W-1:0] index;
            logic [1:0]             wsel;  // word in line
            logic [1:0]             bsel;  // byte in word
        } f;
    } dc_addr_u;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WBUF_WAIT,
        ST_FILL_WAIT,
        ST_RESPOND
    } ctrl_state_e;

endpackage

// ==== logic/dram_cache_cfg.svh ====
`ifndef DRAM_CACHE_CFG_SVH
`define DRAM_CACHE_CFG_SVH

// client side
`define DC_ADDR_W   32  // request address
`define DC_WORD_W   32  // request data
`define DC_BYTES_W  4   // one enable per byte of a word

// cache geometry, direct mapped
`define DC_LINE_W   128 // one line = four words
`define DC_LINES    64
`define DC_INDEX_W  6   // log2 of DC_LINES
`define DC_OFFSET_W 4   // byte offset inside a line
`define DC_TAG_W    22  // what is left of the address

`endif
